/* bench/mc_tb.sv */
module mc_tb;

	// ==================================================
	// Run sizes and constants
	// ==================================================

	localparam int N_DIRECT = 7;
	localparam int N_INIT = 16;
	localparam int N_RAND = 40;
	localparam int ROWS = N_DIRECT + N_INIT + N_RAND;
	localparam int ACK_TIMEOUT = 20;
	// Grant edge, PRESET2, ACCESS and then DONE, where the ack is seen
	localparam int LONE_LATENCY = 4;
	// The random run works on 16 lines starting here
	localparam int RAND_BASE = 8'h40;

	localparam mc_pkg::line_t PAT_A = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
	localparam mc_pkg::line_t PAT_B = 128'hdead_beef_cafe_f00d_1357_9bdf_2468_ace0;
	localparam mc_pkg::line_t PAT_C = 128'h5a5a_a5a5_0f0f_f0f0_c3c3_3c3c_9696_6969;

	logic clk;
	logic rst;
	logic cs0, cs1, cs2, cs3;
	logic we0, we1, we2, we3;
	mc_pkg::adr_t adr0, adr1, adr2, adr3;
	mc_pkg::line_t wdat0, wdat1, wdat2, wdat3;
	mc_pkg::mask_t wmask0, wmask1, wmask2, wmask3;
	logic ack0, ack1, ack2, ack3;
	mc_pkg::line_t rdat;
	logic [3:0] acks;

	assign acks = {ack3, ack2, ack1, ack0};

	// Stimulus table with one row per group of requests
	// row_order lists the channels in the order their acks must come
	logic row_act [ROWS][4];
	logic row_we [ROWS][4];
	mc_pkg::adr_t row_adr [ROWS][4];
	mc_pkg::line_t row_wdat [ROWS][4];
	mc_pkg::mask_t row_wmask [ROWS][4];
	mc_pkg::ch_t row_order [ROWS][4];

	// Reference memory and the last channel that was served
	mc_pkg::line_t model [256];
	mc_pkg::ch_t last_ch;

	int mismatches;
	int other_fails;
	logic timed_out;

	mc_top UUT (
		.clk    (clk),
		.rst    (rst),
		.cs0    (cs0),
		.cs1    (cs1),
		.cs2    (cs2),
		.cs3    (cs3),
		.we0    (we0),
		.we1    (we1),
		.we2    (we2),
		.we3    (we3),
		.adr0   (adr0),
		.adr1   (adr1),
		.adr2   (adr2),
		.adr3   (adr3),
		.wdat0  (wdat0),
		.wdat1  (wdat1),
		.wdat2  (wdat2),
		.wdat3  (wdat3),
		.wmask0 (wmask0),
		.wmask1 (wmask1),
		.wmask2 (wmask2),
		.wmask3 (wmask3),
		.ack0   (ack0),
		.ack1   (ack1),
		.ack2   (ack2),
		.ack3   (ack3),
		.rdat   (rdat)
	);

	always #5 clk = ~clk;

	// ==================================================
	// Channel drive and compare tasks
	// ==================================================

	task automatic set_channel(input int c, input logic sel, input logic w,
			input mc_pkg::adr_t a, input mc_pkg::line_t d, input mc_pkg::mask_t m);
		case (c)
			0: begin
				cs0 = sel;
				we0 = w;
				adr0 = a;
				wdat0 = d;
				wmask0 = m;
			end
			1: begin
				cs1 = sel;
				we1 = w;
				adr1 = a;
				wdat1 = d;
				wmask1 = m;
			end
			2: begin
				cs2 = sel;
				we2 = w;
				adr2 = a;
				wdat2 = d;
				wmask2 = m;
			end
			default: begin
				cs3 = sel;
				we3 = w;
				adr3 = a;
				wdat3 = d;
				wmask3 = m;
			end
		endcase
	endtask

	task automatic check_line(input string name, input mc_pkg::line_t exp,
			input mc_pkg::line_t act);
		if (exp !== act) begin
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_ch(input string name, input mc_pkg::ch_t exp, input mc_pkg::ch_t act);
		if (exp !== act) begin
			$display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			mismatches++;
		end
	endtask

	// ==================================================
	// Reference model
	// ==================================================

	// Bytes whose mask bit is zero take the new data
	task automatic merge_write(input mc_pkg::adr_t a, input mc_pkg::line_t d,
			input mc_pkg::mask_t m);
		for (int b = 0; b < 16; b++) begin
			if (m[b] == 1'b0) begin
				model[a][b*8 +: 8] = d[b*8 +: 8];
			end
		end
	endtask

	// Nearest pending channel above the last one with wraparound
	function automatic mc_pkg::ch_t rr_next(input mc_pkg::ch_t last, input logic [3:0] pend);
		mc_pkg::ch_t idx;
		mc_pkg::ch_t pick;
		pick = last;
		for (int i = 4; i >= 1; i--) begin
			idx = mc_pkg::ch_t'(last + i);
			if (pend[idx]) begin
				pick = idx;
			end
		end
		return pick;
	endfunction

	// ==================================================
	// Table construction
	// ==================================================

	task automatic add_req(input int r, input int k, input int c, input logic w,
			input mc_pkg::adr_t a, input mc_pkg::line_t d, input mc_pkg::mask_t m);
		row_act[r][c] = 1'b1;
		row_we[r][c] = w;
		row_adr[r][c] = a;
		row_wdat[r][c] = d;
		row_wmask[r][c] = m;
		row_order[r][k] = mc_pkg::ch_t'(c);
	endtask

	task automatic build_table();
		int c;
		for (int r = 0; r < ROWS; r++) begin
			for (int j = 0; j < 4; j++) begin
				row_act[r][j] = 1'b0;
				row_we[r][j] = 1'b0;
				row_adr[r][j] = '0;
				row_wdat[r][j] = '0;
				row_wmask[r][j] = '0;
				row_order[r][j] = '0;
			end
		end
		// Full write then a read on another channel
		add_req(0, 0, 0, 1'b1, 8'd5, PAT_A, 16'h0000);
		add_req(1, 0, 2, 1'b0, 8'd5, '0, '0);
		// Mixed mask merges into the line written above
		add_req(2, 0, 1, 1'b1, 8'd5, PAT_B, 16'ha5c3);
		add_req(3, 0, 3, 1'b0, 8'd5, '0, '0);
		// All four at once right after channel 3 was served
		add_req(4, 0, 0, 1'b1, 8'd9, PAT_C, 16'h0000);
		add_req(4, 1, 1, 1'b0, 8'd5, '0, '0);
		add_req(4, 2, 2, 1'b1, 8'd10, PAT_B, 16'h0000);
		add_req(4, 3, 3, 1'b0, 8'd9, '0, '0);
		// A lone channel 1 moves the round robin start to channel 2
		add_req(5, 0, 1, 1'b0, 8'd9, '0, '0);
		add_req(6, 2, 0, 1'b0, 8'd10, '0, '0);
		add_req(6, 3, 1, 1'b0, 8'd9, '0, '0);
		add_req(6, 0, 2, 1'b1, 8'd9, PAT_A, 16'h0ff0);
		add_req(6, 1, 3, 1'b0, 8'd9, '0, '0);
		// Every line of the random window gets a known value first
		for (int i = 0; i < N_INIT; i++) begin
			add_req(N_DIRECT + i, 0, i % 4, 1'b1, mc_pkg::adr_t'(RAND_BASE + i),
				{$urandom, $urandom, $urandom, $urandom}, '0);
		end
		for (int i = 0; i < N_RAND; i++) begin
			c = int'($urandom % 4);
			add_req(N_DIRECT + N_INIT + i, 0, c, 1'($urandom % 2),
				mc_pkg::adr_t'(RAND_BASE + ($urandom % 16)),
				{$urandom, $urandom, $urandom, $urandom}, mc_pkg::mask_t'($urandom));
		end
	endtask

	// ==================================================
	// Applying one row
	// ==================================================

	// Samples at falling edges, counting them until some ack is high
	task automatic wait_ack(output mc_pkg::ch_t got, output int cyc, output logic ok);
		got = '0;
		cyc = 0;
		ok = 1'b0;
		for (int i = 0; i < ACK_TIMEOUT; i++) begin
			@(negedge clk);
			cyc++;
			if (acks != 4'b0) begin
				ok = 1'b1;
				break;
			end
		end
		for (int c = 0; c < 4; c++) begin
			if (acks[c]) begin
				got = mc_pkg::ch_t'(c);
			end
		end
	endtask

	task automatic run_row(input int r);
		logic [3:0] pend;
		int nact;
		int cyc;
		logic ok;
		mc_pkg::ch_t got;
		mc_pkg::ch_t exp_c;
		pend = '0;
		nact = 0;
		for (int c = 0; c < 4; c++) begin
			pend[c] = row_act[r][c];
			if (row_act[r][c]) begin
				nact++;
			end
			set_channel(c, row_act[r][c], row_we[r][c], row_adr[r][c], row_wdat[r][c],
				row_wmask[r][c]);
		end
		for (int k = 0; k < nact; k++) begin
			exp_c = rr_next(last_ch, pend);
			wait_ack(got, cyc, ok);
			if (!ok) begin
				$display("Timeout on row %0d, no acknowledge came within %0d cycles",
					r, ACK_TIMEOUT);
				other_fails++;
				timed_out = 1'b1;
				return;
			end
			if (!$onehot(acks)) begin
				$display("More than one acknowledge high at %0t on row %0d", $time, r);
				other_fails++;
			end
			check_ch("ack channel by round robin", exp_c, got);
			check_ch("ack channel by table order", row_order[r][k], got);
			// Latency is only defined for a request that finds the controller idle
			if (nact == 1) begin
				check_count("ack latency", LONE_LATENCY, cyc);
			end
			if (row_we[r][got]) begin
				merge_write(row_adr[r][got], row_wdat[r][got], row_wmask[r][got]);
			end else begin
				check_line("rdat", model[row_adr[r][got]], rdat);
			end
			pend[got] = 1'b0;
			last_ch = got;
			set_channel(int'(got), 1'b0, 1'b0, '0, '0, '0);
		end
		// One quiet cycle lets the controller reach IDLE before the next row
		@(negedge clk);
		if (acks != 4'b0) begin
			$display("Acknowledge still high one cycle later at %0t on row %0d", $time, r);
			other_fails++;
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		void'($urandom(95382));
		clk = 1'b0;
		rst = 1'b1;
		mismatches = 0;
		other_fails = 0;
		timed_out = 1'b0;
		last_ch = mc_pkg::ch_t'(3);
		for (int c = 0; c < 4; c++) begin
			set_channel(c, 1'b0, 1'b0, '0, '0, '0);
		end
		for (int a = 0; a < 256; a++) begin
			model[a] = '0;
		end
		build_table();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		// No channel selects, so no ack may show up
		repeat (8) begin
			@(negedge clk);
			if (acks != 4'b0) begin
				$display("Acknowledge high at %0t while no channel selects", $time);
				other_fails++;
			end
		end
		for (int r = 0; r < ROWS; r++) begin
			run_row(r);
			if (timed_out) begin
				break;
			end
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatches, other_fails);
		if (mismatches == 0 && other_fails == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* run.sh */
#!/bin/sh
# Builds the memory controller testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f verilog.f --top-module mc_tb \
	--Mdir "$BUILD_DIR" -o mc_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/mc_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
	echo "Result: passed"
	exit 0
else
	echo "Result: failed, see $LOG"
	exit 1
fi

/* source/mc_arbiter.sv */
module mc_arbiter (
	input  logic         clk,
	input  logic         rst,
	input  logic         grant,
	input  logic         cs0,
	input  logic         cs1,
	input  logic         cs2,
	input  logic         cs3,
	output logic         req_any,
	output mc_pkg::ch_t  ch
);

	// Select levels gathered by channel number
	logic [mc_pkg::NUM_CH-1:0] req;

	// Channel that wins the next grant
	mc_pkg::ch_t ch_nx;

	assign req = {cs3, cs2, cs1, cs0};

	// Any raised select level starts a transaction
	assign req_any = |req;

	// Search upward from the channel after the last one granted
	// The last granted channel itself is tried last, so every requester
	// is served within four transactions
	always_comb begin
		mc_pkg::ch_t idx;
		logic        found;
		ch_nx = ch;
		found = 1'b0;
		idx   = ch;
		for (int i = 1; i <= mc_pkg::NUM_CH; i++) begin
			idx = mc_pkg::ch_t'(ch + i);
			if (!found && req[idx]) begin
				ch_nx = idx;
				found = 1'b1;
			end
		end
	end

	// ch holds between grants so the datapath and the acknowledge
	// decode see one channel for the whole transaction
	// Channel 3 after reset gives channel 0 the first turn
	always_ff @(posedge clk) begin
		if (rst) begin
			ch <= mc_pkg::ch_t'(mc_pkg::NUM_CH - 1);
		end else if (grant) begin
			ch <= ch_nx;
		end
	end

endmodule

/* source/mc_data_select.sv */
module mc_data_select (
	input  logic            clk,
	input  logic            rst,
	input  mc_pkg::state_t  state,
	input  mc_pkg::ch_t     ch,
	input  mc_pkg::adr_t    adr0,
	input  mc_pkg::adr_t    adr1,
	input  mc_pkg::adr_t    adr2,
	input  mc_pkg::adr_t    adr3,
	input  mc_pkg::line_t   wdat0,
	input  mc_pkg::line_t   wdat1,
	input  mc_pkg::line_t   wdat2,
	input  mc_pkg::line_t   wdat3,
	input  logic            we0,
	input  logic            we1,
	input  logic            we2,
	input  logic            we3,
	output mc_pkg::adr_t    adr_q,
	output mc_pkg::line_t   wdat_q,
	output logic            we_q
);

	// ==================================================
	// Address and write data
	// ==================================================

	// Captured once per transaction, at the end of PRESET1
	// The RAM only looks at them while ram_en is high
	always_ff @(posedge clk) begin
		if (state == mc_pkg::PRESET1) begin
			case (ch)
				2'd0: begin
					adr_q  <= adr0;
					wdat_q <= wdat0;
				end
				2'd1: begin
					adr_q  <= adr1;
					wdat_q <= wdat1;
				end
				2'd2: begin
					adr_q  <= adr2;
					wdat_q <= wdat2;
				end
				default: begin
					adr_q  <= adr3;
					wdat_q <= wdat3;
				end
			endcase
		end
	end

	// ==================================================
	// Write flag
	// ==================================================

	// Steers the FSM's RAM write strobe for this transaction
	always_ff @(posedge clk) begin
		if (rst) begin
			we_q <= 1'b0;
		end else if (state == mc_pkg::PRESET1) begin
			case (ch)
				2'd0: we_q <= we0;
				2'd1: we_q <= we1;
				2'd2: we_q <= we2;
				default: we_q <= we3;
			endcase
		end
	end

endmodule

/* source/mc_fsm.sv */
module mc_fsm (
	input  logic            clk,
	input  logic            rst,
	input  logic            req_any,
	input  mc_pkg::ch_t     ch,
	input  logic            we_q,
	output mc_pkg::state_t  state,
	output logic            grant,
	output logic            ram_en,
	output logic            ram_we,
	output logic            ack0,
	output logic            ack1,
	output logic            ack2,
	output logic            ack3
);

	// Next state of the sequencer
	mc_pkg::state_t state_nx;

	// ==================================================
	// Transaction sequencing
	// ==================================================

	// A transaction starts only from IDLE, and only when some channel asks
	// The arbiter picks the channel on the same edge that leaves IDLE
	assign grant = (state == mc_pkg::IDLE) && req_any;

	// Every step after IDLE takes exactly one cycle, with no waiting
	always_comb begin
		state_nx = state;
		case (state)
			mc_pkg::IDLE: begin
				if (req_any) begin
					state_nx = mc_pkg::PRESET1;
				end
			end
			// Mask and data of the chosen channel are captured here
			mc_pkg::PRESET1: begin
				state_nx = mc_pkg::PRESET2;
			end
			// The mask moves to its output stage
			mc_pkg::PRESET2: begin
				state_nx = mc_pkg::ACCESS;
			end
			// The RAM writes or reads at the end of this cycle
			mc_pkg::ACCESS: begin
				state_nx = mc_pkg::DONE;
			end
			// The channel sees its acknowledge and the read data
			mc_pkg::DONE: begin
				state_nx = mc_pkg::IDLE;
			end
			default: begin
				state_nx = mc_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mc_pkg::IDLE;
		end else begin
			state <= state_nx;
		end
	end

	// ==================================================
	// Registered strobes
	// ==================================================

	// The RAM enable is set up in PRESET2 so that it is high during ACCESS
	// The write flag was captured at the end of PRESET1 and is stable now
	always_ff @(posedge clk) begin
		if (rst) begin
			ram_en <= 1'b0;
			ram_we <= 1'b0;
		end else begin
			ram_en <= (state == mc_pkg::PRESET2);
			ram_we <= (state == mc_pkg::PRESET2) && we_q;
		end
	end

	// The acknowledge of the granted channel is high during DONE
	// Only one of them can be high, since ch holds one channel number
	always_ff @(posedge clk) begin
		if (rst) begin
			ack0 <= 1'b0;
			ack1 <= 1'b0;
			ack2 <= 1'b0;
			ack3 <= 1'b0;
		end else begin
			ack0 <= (state == mc_pkg::ACCESS) && (ch == 2'd0);
			ack1 <= (state == mc_pkg::ACCESS) && (ch == 2'd1);
			ack2 <= (state == mc_pkg::ACCESS) && (ch == 2'd2);
			ack3 <= (state == mc_pkg::ACCESS) && (ch == 2'd3);
		end
	end

endmodule

/* source/mc_mask_select.sv */
module mc_mask_select (
	input  logic            clk,
	input  logic            rst,
	input  mc_pkg::state_t  state,
	input  mc_pkg::ch_t     ch,
	input  mc_pkg::mask_t   wmask0,
	input  mc_pkg::mask_t   wmask1,
	input  mc_pkg::mask_t   wmask2,
	input  mc_pkg::mask_t   wmask3,
	output mc_pkg::mask_t   mask
);

	// First stage that holds the granted channel's mask
	mc_pkg::mask_t mask2;

	// A zero bit in the mask enables the byte
	// The channel is fixed by the time PRESET1 is reached
	always_ff @(posedge clk) begin
		if (rst) begin
			mask2 <= '0;
		end else if (state == mc_pkg::PRESET1) begin
			case (ch)
				2'd0: mask2 <= wmask0;
				2'd1: mask2 <= wmask1;
				2'd2: mask2 <= wmask2;
				default: mask2 <= wmask3;
			endcase
		end
	end

	// Second stage feeds the RAM and stays put through ACCESS
	always_ff @(posedge clk) begin
		if (rst) begin
			mask <= '0;
		end else if (state == mc_pkg::PRESET2) begin
			mask <= mask2;
		end
	end

endmodule

/* source/mc_pkg.sv */
package mc_pkg;

	// ==================================================
	// Sizes
	// ==================================================

	// Four requesting channels share the memory
	localparam int NUM_CH = 4;

	// One memory line is 128 bits, written a byte at a time
	localparam int DATA_W = 128;

	// One mask bit per byte of the line
	localparam int MASK_W = DATA_W / 8;

	// 256 lines need an 8-bit line address
	localparam int ADR_W = 8;

	// ==================================================
	// Types
	// ==================================================

	// Control states of one memory transaction
	// The encoding is kept at four bits to leave room for more steps
	typedef enum logic [3:0] {
		IDLE    = 4'd0,
		PRESET1 = 4'd1,
		PRESET2 = 4'd2,
		ACCESS  = 4'd3,
		DONE    = 4'd4
	} state_t;

	// Channel number
	typedef logic [$clog2(NUM_CH)-1:0] ch_t;

	// One data line
	typedef logic [DATA_W-1:0] line_t;

	// Byte mask in which a zero bit enables the byte
	typedef logic [MASK_W-1:0] mask_t;

	// Line address
	typedef logic [ADR_W-1:0] adr_t;

endpackage

/* source/mc_ram.sv */
module mc_ram (
	input  logic           clk,
	input  logic           en,
	input  logic           we,
	input  mc_pkg::adr_t   adr,
	input  mc_pkg::line_t  wdat,
	input  mc_pkg::mask_t  mask,
	output mc_pkg::line_t  rdat
);

	// One line per address
	mc_pkg::line_t mem [0:(2**mc_pkg::ADR_W)-1];

	// ==================================================
	// Masked write
	// ==================================================

	// Each byte lane is written only when its mask bit is zero
	// Lanes with a one keep their old contents
	always_ff @(posedge clk) begin
		if (en && we) begin
			for (int b = 0; b < mc_pkg::MASK_W; b++) begin
				if (!mask[b]) begin
					mem[adr][b*8 +: 8] <= wdat[b*8 +: 8];
				end
			end
		end
	end

	// ==================================================
	// Registered read
	// ==================================================

	// The read line shows up in the cycle after ACCESS, which is DONE
	// It is held until the next read so the channel can sample late
	always_ff @(posedge clk) begin
		if (en && !we) begin
			rdat <= mem[adr];
		end
	end

endmodule

/* source/mc_top.sv */
module mc_top (
	input  logic           clk,
	input  logic           rst,
	input  logic           cs0,
	input  logic           cs1,
	input  logic           cs2,
	input  logic           cs3,
	input  logic           we0,
	input  logic           we1,
	input  logic           we2,
	input  logic           we3,
	input  mc_pkg::adr_t   adr0,
	input  mc_pkg::adr_t   adr1,
	input  mc_pkg::adr_t   adr2,
	input  mc_pkg::adr_t   adr3,
	input  mc_pkg::line_t  wdat0,
	input  mc_pkg::line_t  wdat1,
	input  mc_pkg::line_t  wdat2,
	input  mc_pkg::line_t  wdat3,
	input  mc_pkg::mask_t  wmask0,
	input  mc_pkg::mask_t  wmask1,
	input  mc_pkg::mask_t  wmask2,
	input  mc_pkg::mask_t  wmask3,
	output logic           ack0,
	output logic           ack1,
	output logic           ack2,
	output logic           ack3,
	output mc_pkg::line_t  rdat
);

	// ==================================================
	// Control side
	// ==================================================

	logic            req_any;
	logic            grant;
	logic            ram_en;
	logic            ram_we;
	mc_pkg::ch_t     ch;
	mc_pkg::state_t  state;

	// Datapath registers feeding the RAM
	mc_pkg::mask_t   mask;
	mc_pkg::adr_t    adr_q;
	mc_pkg::line_t   wdat_q;
	logic            we_q;

	mc_fsm u_fsm (
		.clk     (clk),
		.rst     (rst),
		.req_any (req_any),
		.ch      (ch),
		.we_q    (we_q),
		.state   (state),
		.grant   (grant),
		.ram_en  (ram_en),
		.ram_we  (ram_we),
		.ack0    (ack0),
		.ack1    (ack1),
		.ack2    (ack2),
		.ack3    (ack3)
	);

	mc_arbiter u_arbiter (
		.clk     (clk),
		.rst     (rst),
		.grant   (grant),
		.cs0     (cs0),
		.cs1     (cs1),
		.cs2     (cs2),
		.cs3     (cs3),
		.req_any (req_any),
		.ch      (ch)
	);

	// ==================================================
	// Datapath
	// ==================================================

	mc_mask_select u_mask_select (
		.clk    (clk),
		.rst    (rst),
		.state  (state),
		.ch     (ch),
		.wmask0 (wmask0),
		.wmask1 (wmask1),
		.wmask2 (wmask2),
		.wmask3 (wmask3),
		.mask   (mask)
	);

	mc_data_select u_data_select (
		.clk    (clk),
		.rst    (rst),
		.state  (state),
		.ch     (ch),
		.adr0   (adr0),
		.adr1   (adr1),
		.adr2   (adr2),
		.adr3   (adr3),
		.wdat0  (wdat0),
		.wdat1  (wdat1),
		.wdat2  (wdat2),
		.wdat3  (wdat3),
		.we0    (we0),
		.we1    (we1),
		.we2    (we2),
		.we3    (we3),
		.adr_q  (adr_q),
		.wdat_q (wdat_q),
		.we_q   (we_q)
	);

	// Read data goes straight to the shared rdat port
	mc_ram u_ram (
		.clk  (clk),
		.en   (ram_en),
		.we   (ram_we),
		.adr  (adr_q),
		.wdat (wdat_q),
		.mask (mask),
		.rdat (rdat)
	);

endmodule

/* verilog.f */
source/mc_pkg.sv
source/mc_fsm.sv
source/mc_arbiter.sv
source/mc_mask_select.sv
source/mc_data_select.sv
source/mc_ram.sv
source/mc_top.sv
bench/mc_tb.sv
